// File: lsq_alloc.sv
`timescale 1ns/10ps

module lsq_alloc #(
	parameter int NUM_ENTRIES = lsq_pkg::DEF_ENTRIES
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   disp_valid_i,
	input  lsq_pkg::ls_op_t         disp_op_i,
	input  lsq_pkg::data_t          disp_base_i,
	input  lsq_pkg::off_t           disp_off_i,
	input  lsq_pkg::data_t          disp_val_i,
	input  lsq_pkg::tag_t           disp_tag_i,
	output logic [NUM_ENTRIES-1:0] alloc_o,
	output lsq_pkg::ls_op_t         op_o,
	output lsq_pkg::addr_t          addr_o,
	output lsq_pkg::data_t          val_o,
	output lsq_pkg::tag_t           tag_o
);

	localparam int idx_w = $clog2(NUM_ENTRIES);

	logic [idx_w-1:0] tail_q;
	lsq_pkg::data_t    off_ext;
	lsq_pkg::data_t    sum;

	always_ff @(posedge clk) begin
		if (!rst_n)
			tail_q <= '0;
		else if (disp_valid_i)
			tail_q <= (tail_q == idx_w'(NUM_ENTRIES - 1)) ? '0 : tail_q + 1'b1;
	end

	// one strobe for the slot under the tail
	always_comb begin
		alloc_o = '0;
		if (disp_valid_i)
			alloc_o[tail_q] = 1'b1;
	end

	// address = base + sign extended offset, low bits only
	assign off_ext = {{(lsq_pkg::data_w - lsq_pkg::off_w){disp_off_i[lsq_pkg::off_w-1]}},
		disp_off_i};
	assign sum     = disp_base_i + off_ext;
	assign addr_o  = sum[lsq_pkg::addr_w-1:0];

	assign op_o  = disp_op_i;
	assign val_o = disp_val_i;
	assign tag_o = disp_tag_i;

endmodule

// File: lsq_entry.sv
`timescale 1ns/10ps

module lsq_entry #(
	parameter int NUM_CDB = lsq_pkg::DEF_CDB
) (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           alloc_i,
	input  lsq_pkg::ls_op_t op_i,
	input  lsq_pkg::addr_t  addr_i,
	input  lsq_pkg::data_t  val_i,
	input  lsq_pkg::tag_t   tag_i,
	input  logic           retire_i,
	input  logic           cdb_valid_i [NUM_CDB],
	input  lsq_pkg::tag_t   cdb_tag_i [NUM_CDB],
	input  lsq_pkg::data_t  cdb_data_i [NUM_CDB],
	output logic           busy_o,
	output lsq_pkg::ls_op_t op_o,
	output lsq_pkg::addr_t  addr_o,
	output lsq_pkg::data_t  data_o,
	output logic           ready_o
);

	logic           busy_q;
	lsq_pkg::tag_t   tag_q;
	lsq_pkg::ls_op_t op_q;
	lsq_pkg::addr_t  addr_q;
	lsq_pkg::data_t  data_q;

	// tag being watched this cycle, the incoming one on allocation
	lsq_pkg::tag_t   look_tag;
	logic           hit;
	lsq_pkg::data_t  hit_data;

	assign look_tag = alloc_i ? tag_i : tag_q;

	// scan downwards so the lowest numbered bus wins on a double match
	always_comb begin
		hit      = 1'b0;
		hit_data = '0;
		for (int b = NUM_CDB - 1; b >= 0; b--) begin
			if (cdb_valid_i[b] && (cdb_tag_i[b] == look_tag)) begin
				hit      = 1'b1;
				hit_data = cdb_data_i[b];
			end
		end
		if (look_tag == '0)
			hit = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			tag_q  <= '0;
		end else if (alloc_i) begin
			busy_q <= 1'b1;
			tag_q  <= hit ? '0 : tag_i;
		end else begin
			if (retire_i)
				busy_q <= 1'b0;
			if (busy_q && hit)
				tag_q <= '0;
		end
	end

	// instruction fields and the store value
	always_ff @(posedge clk) begin
		if (alloc_i) begin
			op_q   <= op_i;
			addr_q <= addr_i;
			data_q <= hit ? hit_data : val_i;
		end else if (busy_q && hit) begin
			data_q <= hit_data;
		end
	end

	assign busy_o  = busy_q;
	assign op_o    = op_q;
	assign addr_o  = addr_q;
	assign data_o  = data_q;
	// loads never wait, stores wait for their value
	assign ready_o = busy_q && ((op_q == lsq_pkg::LS_LOAD) || (tag_q == '0));

	// dispatch credits must keep the tail off a slot that has not retired yet
	a_no_alloc_busy: assert property (@(posedge clk) disable iff (!rst_n)
		alloc_i |-> !busy_q);

endmodule

// File: lsq_issue.sv
`timescale 1ns/10ps

module lsq_issue #(
	parameter int NUM_ENTRIES = lsq_pkg::DEF_ENTRIES,
	parameter int MEM_CREDITS = lsq_pkg::DEF_MEM_CREDITS
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [NUM_ENTRIES-1:0]         busy_i,
	input  logic [NUM_ENTRIES-1:0]         ready_i,
	input  lsq_pkg::ls_op_t                 op_i [NUM_ENTRIES],
	input  lsq_pkg::addr_t                  addr_i [NUM_ENTRIES],
	input  lsq_pkg::data_t                  data_i [NUM_ENTRIES],
	input  logic                           mem_credit_i,
	output logic [NUM_ENTRIES-1:0]         retire_o,
	output logic                           disp_credit_o,
	output logic                           mem_req_o,
	output logic                           mem_we_o,
	output lsq_pkg::addr_t                  mem_addr_o,
	output lsq_pkg::data_t                  mem_wdata_o,
	output logic [$clog2(NUM_ENTRIES)-1:0] mem_tag_o
);

	localparam int idx_w = $clog2(NUM_ENTRIES);
	localparam int cnt_w = $clog2(MEM_CREDITS + 1);

	logic [idx_w-1:0] head_q;
	logic [cnt_w-1:0] mcred_q;
	logic             issue;

	// oldest slot goes out once it is ready and memory has room
	assign issue = ready_i[head_q] && (mcred_q != '0);

	always_ff @(posedge clk) begin
		if (!rst_n)
			head_q <= '0;
		else if (issue)
			head_q <= (head_q == idx_w'(NUM_ENTRIES - 1)) ? '0 : head_q + 1'b1;
	end

	// request buffers left on the memory side
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mcred_q <= cnt_w'(MEM_CREDITS);
		end else begin
			case ({issue, mem_credit_i})
				2'b10:   mcred_q <= mcred_q - 1'b1;
				2'b01:   mcred_q <= mcred_q + 1'b1;
				default: mcred_q <= mcred_q;
			endcase
		end
	end

	// free the head slot at the issue edge
	always_comb begin
		retire_o = '0;
		if (issue)
			retire_o[head_q] = 1'b1;
	end

	assign disp_credit_o = issue;

	assign mem_req_o   = issue;
	assign mem_we_o    = issue && (op_i[head_q] == lsq_pkg::LS_STORE);
	assign mem_addr_o  = addr_i[head_q];
	assign mem_wdata_o = data_i[head_q];
	// slot number lets the load data find its way back
	assign mem_tag_o   = head_q;

	// memory must not return more credits than it was given
	a_mcred_bound: assert property (@(posedge clk) disable iff (!rst_n)
		mcred_q <= cnt_w'(MEM_CREDITS));

	// a slot only reports ready while it holds an instruction
	a_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_o |-> busy_i[head_q]);

endmodule

// File: lsq_pkg.sv
package lsq_pkg;

	// register values and broadcast results are one word
	localparam int data_w = 32;

	// memory address width, base plus offset is cut to this
	localparam int addr_w = 10;

	// signed immediate offset carried by memory instructions
	localparam int off_w = 12;

	// producer tag, zero means the value is already present
	localparam int tag_w = 4;

	typedef logic [data_w-1:0] data_t;
	typedef logic [addr_w-1:0] addr_t;
	typedef logic [off_w-1:0]  off_t;
	typedef logic [tag_w-1:0]  tag_t;

	typedef enum logic {
		LS_LOAD  = 1'b0,
		LS_STORE = 1'b1
	} ls_op_t;

	// buffer depth
	localparam int DEF_ENTRIES = 6;

	// number of result broadcast buses snooped by every slot
	localparam int DEF_CDB = 6;

	// request buffers on the memory side
	localparam int DEF_MEM_CREDITS = 2;

endpackage

// File: lsq_top.f
lsq_pkg.sv
lsq_entry.sv
lsq_alloc.sv
lsq_issue.sv
lsq_top.sv
tb_lsq.sv

// File: lsq_top.sv
`timescale 1ns/10ps

module lsq_top #(
	parameter int NUM_ENTRIES = lsq_pkg::DEF_ENTRIES,
	parameter int NUM_CDB     = lsq_pkg::DEF_CDB,
	parameter int MEM_CREDITS = lsq_pkg::DEF_MEM_CREDITS
) (
	input  logic                           clk,
	input  logic                           rst_n,
	// dispatch
	input  logic                           disp_valid_i,
	input  lsq_pkg::ls_op_t                 disp_op_i,
	input  lsq_pkg::data_t                  disp_base_i,
	input  lsq_pkg::off_t                   disp_off_i,
	input  lsq_pkg::data_t                  disp_val_i,
	input  lsq_pkg::tag_t                   disp_tag_i,
	output logic                           disp_credit_o,
	// result broadcast buses
	input  logic                           cdb_valid_i [NUM_CDB],
	input  lsq_pkg::tag_t                   cdb_tag_i [NUM_CDB],
	input  lsq_pkg::data_t                  cdb_data_i [NUM_CDB],
	// memory port
	output logic                           mem_req_o,
	output logic                           mem_we_o,
	output lsq_pkg::addr_t                  mem_addr_o,
	output lsq_pkg::data_t                  mem_wdata_o,
	output logic [$clog2(NUM_ENTRIES)-1:0] mem_tag_o,
	input  logic                           mem_credit_i
);

	logic [NUM_ENTRIES-1:0] alloc;
	logic [NUM_ENTRIES-1:0] retire;
	logic [NUM_ENTRIES-1:0] busy;
	logic [NUM_ENTRIES-1:0] ready;
	lsq_pkg::ls_op_t         new_op;
	lsq_pkg::addr_t          new_addr;
	lsq_pkg::data_t          new_val;
	lsq_pkg::tag_t           new_tag;
	lsq_pkg::ls_op_t         slot_op [NUM_ENTRIES];
	lsq_pkg::addr_t          slot_addr [NUM_ENTRIES];
	lsq_pkg::data_t          slot_data [NUM_ENTRIES];

	lsq_alloc #(.NUM_ENTRIES(NUM_ENTRIES)) u_alloc (
		.clk, .rst_n,
		.disp_valid_i, .disp_op_i, .disp_base_i, .disp_off_i, .disp_val_i, .disp_tag_i,
		.alloc_o(alloc), .op_o(new_op), .addr_o(new_addr), .val_o(new_val), .tag_o(new_tag)
	);

	for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_slot
		lsq_entry #(.NUM_CDB(NUM_CDB)) u_entry (
			.clk, .rst_n,
			.alloc_i(alloc[i]), .op_i(new_op), .addr_i(new_addr), .val_i(new_val),
			.tag_i(new_tag), .retire_i(retire[i]),
			.cdb_valid_i, .cdb_tag_i, .cdb_data_i,
			.busy_o(busy[i]), .op_o(slot_op[i]), .addr_o(slot_addr[i]),
			.data_o(slot_data[i]), .ready_o(ready[i])
		);
	end

	lsq_issue #(.NUM_ENTRIES(NUM_ENTRIES), .MEM_CREDITS(MEM_CREDITS)) u_issue (
		.clk, .rst_n,
		.busy_i(busy), .ready_i(ready), .op_i(slot_op), .addr_i(slot_addr),
		.data_i(slot_data), .mem_credit_i,
		.retire_o(retire), .disp_credit_o,
		.mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_tag_o
	);

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsq -f lsq_top.f -o sim_lsq

out=$(./obj_dir/sim_lsq 2>&1) || true
echo "$out"

if grep -q "Everything OK" <<< "$out"; then
	exit 0
fi
echo "simulation did not pass"
exit 1

// File: tb_lsq.sv
`timescale 1ns/10ps

module tb_lsq;

	localparam int NUM_ENTRIES = lsq_pkg::DEF_ENTRIES;
	localparam int NUM_CDB     = lsq_pkg::DEF_CDB;
	localparam int MEM_CREDITS = lsq_pkg::DEF_MEM_CREDITS;
	localparam int idx_w       = $clog2(NUM_ENTRIES);
	localparam int n_tags      = 1 << lsq_pkg::tag_w;
	localparam int n_rand      = 300;
	// directed loads, stores, tag waits and credit hold, then the random run
	localparam int n_instr     = 8 + 3 + 6 + 10 + n_rand;
	localparam real limit_ns   = 40.0 * (20 * n_instr + 200);

	typedef struct packed {
		lsq_pkg::ls_op_t op;
		lsq_pkg::data_t  base;
		lsq_pkg::off_t   off;
		lsq_pkg::data_t  val;
		lsq_pkg::tag_t   tag;
	} instr_t;

	typedef struct packed {
		lsq_pkg::ls_op_t  op;
		lsq_pkg::addr_t   addr;
		lsq_pkg::data_t   data;
		logic [idx_w-1:0] slot;
		lsq_pkg::tag_t    tag;
		int               gen;
	} req_t;

	logic             clk;
	logic             rst_n = 1'b0;
	logic             disp_valid_i = 1'b0;
	lsq_pkg::ls_op_t  disp_op_i = lsq_pkg::LS_LOAD;
	lsq_pkg::data_t   disp_base_i = '0;
	lsq_pkg::off_t    disp_off_i = '0;
	lsq_pkg::data_t   disp_val_i = '0;
	lsq_pkg::tag_t    disp_tag_i = '0;
	logic             disp_credit_o;
	logic             cdb_valid_i [NUM_CDB] = '{default: 1'b0};
	lsq_pkg::tag_t    cdb_tag_i [NUM_CDB] = '{default: '0};
	lsq_pkg::data_t   cdb_data_i [NUM_CDB] = '{default: '0};
	logic             mem_req_o;
	logic             mem_we_o;
	lsq_pkg::addr_t   mem_addr_o;
	lsq_pkg::data_t   mem_wdata_o;
	logic [idx_w-1:0] mem_tag_o;
	logic             mem_credit_i = 1'b0;

	integer         seed = 32'hdd7581e9;
	instr_t         disp_q [$];
	req_t           exp_q [$];
	int             due_q [$];
	instr_t         rand_prog [n_rand];
	// value each store tag will be broadcast with, and whether it is still owed
	lsq_pkg::data_t tag_val [n_tags] = '{default: '0};
	logic           tag_wait [n_tags] = '{default: 1'b0};
	int             tag_gen [n_tags] = '{default: 0};
	int             n_disp = 0;
	int             n_req = 0;
	int             n_credit = 0;
	int             n_pushed = 0;
	int             cycle = 0;
	int             bcast_mode = 1;
	logic           mem_hold = 1'b0;
	int             base_cnt;

	lsq_top #(
		.NUM_ENTRIES(NUM_ENTRIES),
		.NUM_CDB(NUM_CDB),
		.MEM_CREDITS(MEM_CREDITS)
	) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_addr(input lsq_pkg::addr_t got, input lsq_pkg::addr_t exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED mem_addr_o got %h expected %h", got, exp));
	endtask

	task automatic check_data(input lsq_pkg::data_t got, input lsq_pkg::data_t exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED mem_wdata_o got %h expected %h", got, exp));
	endtask

	task automatic check_tag(input logic [idx_w-1:0] got, input logic [idx_w-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED mem_tag_o got %h expected %h", got, exp));
	endtask

	task automatic check_op(input lsq_pkg::ls_op_t got, input lsq_pkg::ls_op_t exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED mem_we_o got %h expected %h", got, exp));
	endtask

	// request the memory port should show for one dispatched instruction
	function automatic req_t expected_request(instr_t ins, logic [idx_w-1:0] slot);
		req_t           r;
		lsq_pkg::data_t sum;
		sum    = ins.base + lsq_pkg::data_t'(int'($signed(ins.off)));
		r.op   = ins.op;
		r.addr = sum[lsq_pkg::addr_w-1:0];
		r.data = (ins.tag == '0) ? ins.val : tag_val[ins.tag];
		r.slot = slot;
		r.tag  = (ins.op == lsq_pkg::LS_STORE) ? ins.tag : '0;
		r.gen  = tag_gen[ins.tag];
		return r;
	endfunction

	task automatic push_instr(input lsq_pkg::ls_op_t op, input lsq_pkg::data_t base,
		input lsq_pkg::off_t off, input lsq_pkg::data_t val, input lsq_pkg::tag_t tag);
		instr_t ins;
		ins.op   = op;
		ins.base = base;
		ins.off  = off;
		ins.val  = val;
		ins.tag  = tag;
		disp_q.push_back(ins);
		n_pushed++;
	endtask

	task automatic drain_requests();
		wait (n_req == n_pushed);
		@(negedge clk);
	endtask

	// dispatcher and result buses, one credit per free slot
	always @(posedge clk) begin
		instr_t ins;
		logic   used [NUM_CDB];
		logic   taken [n_tags];
		int     b;
		int     t;
		disp_valid_i <= 1'b0;
		for (int i = 0; i < NUM_CDB; i++) begin
			used[i] = 1'b0;
			cdb_valid_i[i] <= 1'b0;
		end
		for (int k = 0; k < n_tags; k++)
			taken[k] = 1'b0;
		if (rst_n && (n_disp - n_credit < NUM_ENTRIES) && disp_q.size() > 0) begin
			ins = disp_q.pop_front();
			if (ins.op == lsq_pkg::LS_STORE && ins.tag != '0 && !tag_wait[ins.tag]) begin
				tag_wait[ins.tag] = 1'b1;
				tag_val[ins.tag]  = $random(seed);
			end
			exp_q.push_back(expected_request(ins, idx_w'(n_disp % NUM_ENTRIES)));
			n_disp++;
			disp_valid_i <= 1'b1;
			disp_op_i    <= ins.op;
			disp_base_i  <= ins.base;
			disp_off_i   <= ins.off;
			disp_val_i   <= ins.val;
			disp_tag_i   <= ins.tag;
		end
		// owed store tags go out on a random free bus
		for (int k = 1; k < n_tags; k++) begin
			if (tag_wait[k] && (bcast_mode == 2 || (bcast_mode == 1 && $random(seed) % 4 == 0))) begin
				b = int'($unsigned($random(seed)) % NUM_CDB);
				for (int n = 0; n < NUM_CDB && used[b]; n++)
					b = (b + 1) % NUM_CDB;
				if (!used[b]) begin
					used[b]  = 1'b1;
					taken[k] = 1'b1;
					cdb_valid_i[b] <= 1'b1;
					cdb_tag_i[b]   <= lsq_pkg::tag_t'(k);
					cdb_data_i[b]  <= tag_val[k];
					tag_wait[k] = 1'b0;
					tag_gen[k]++;
				end
			end
		end
		// unrelated traffic on idle buses
		for (int i = 0; i < NUM_CDB; i++) begin
			t = int'($unsigned($random(seed)) % n_tags);
			if (!used[i] && !tag_wait[t] && !taken[t] && $random(seed) % 3 == 0) begin
				taken[t] = 1'b1;
				cdb_valid_i[i] <= 1'b1;
				cdb_tag_i[i]   <= lsq_pkg::tag_t'(t);
				cdb_data_i[i]  <= $random(seed);
			end
		end
	end

	// memory returns one credit per request after 0 to 3 cycles
	always @(posedge clk) begin
		cycle++;
		if (!mem_hold && due_q.size() > 0 && due_q[0] <= cycle) begin
			void'(due_q.pop_front());
			mem_credit_i <= 1'b1;
		end else begin
			mem_credit_i <= 1'b0;
		end
	end

	// compare every request with the oldest expected one
	always @(negedge clk) begin
		req_t r;
		if (rst_n) begin
			if (disp_credit_o === 1'b1)
				n_credit++;
			if (disp_credit_o !== mem_req_o) begin
				abort_run("dispatch credit pulse and memory request disagree");
			end else if (mem_req_o === 1'b1) begin
				if (exp_q.size() == 0) begin
					abort_run("memory request with no instruction outstanding");
				end else begin
					r = exp_q.pop_front();
					check_op(mem_we_o ? lsq_pkg::LS_STORE : lsq_pkg::LS_LOAD, r.op);
					check_addr(mem_addr_o, r.addr);
					check_tag(mem_tag_o, r.slot);
					if (r.op == lsq_pkg::LS_STORE)
						check_data(mem_wdata_o, r.data);
					if (r.tag != '0 && tag_gen[r.tag] <= r.gen)
						abort_run("store issued before its tag was broadcast");
					n_req++;
					due_q.push_back(cycle + 1 + int'($unsigned($random(seed)) % 4));
				end
			end
		end
	end

	initial begin
		#(limit_ns);
		abort_run("timeout while waiting for the memory requests");
	end

	initial begin
		for (int i = 0; i < n_rand; i++) begin
			rand_prog[i].op   = ($random(seed) & 1) ? lsq_pkg::LS_STORE : lsq_pkg::LS_LOAD;
			rand_prog[i].base = $random(seed);
			rand_prog[i].off  = lsq_pkg::off_t'($random(seed));
			rand_prog[i].val  = $random(seed);
			rand_prog[i].tag  = ($random(seed) % 3 == 0) ? '0 : lsq_pkg::tag_t'($random(seed));
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// idle after reset, both outputs must read as a clean low
		repeat (10) begin
			@(negedge clk);
			if (mem_req_o !== 1'b0 || disp_credit_o !== 1'b0)
				abort_run("request or dispatch credit seen before any dispatch");
		end

		// loads with positive and negative offsets, slot number wraps
		for (int i = 0; i < 8; i++) begin
			if (i % 2 == 1)
				push_instr(lsq_pkg::LS_LOAD, lsq_pkg::data_t'(i), lsq_pkg::off_t'(-9 * i), '0, '0);
			else
				push_instr(lsq_pkg::LS_LOAD, lsq_pkg::data_t'(32'h3f0 + 8 * i),
					lsq_pkg::off_t'(33 * i), '0, '0);
		end
		drain_requests();

		for (int i = 0; i < 3; i++)
			push_instr(lsq_pkg::LS_STORE, lsq_pkg::data_t'(32'h80 + 4 * i), lsq_pkg::off_t'(i),
				lsq_pkg::data_t'(32'hcafe_0000 + i), '0);
		drain_requests();

		// a store waiting on tag 5 holds back the loads behind it
		bcast_mode = 0;
		push_instr(lsq_pkg::LS_STORE, 32'h40, lsq_pkg::off_t'(-2), 32'h1111_1111, 4'd5);
		for (int i = 0; i < 3; i++)
			push_instr(lsq_pkg::LS_LOAD, lsq_pkg::data_t'(32'h60 + i), '0, '0, '0);
		repeat (15) @(posedge clk);
		@(negedge clk);
		bcast_mode = 1;
		drain_requests();

		// broadcast in the same cycle as allocation
		bcast_mode = 2;
		push_instr(lsq_pkg::LS_STORE, 32'h20, lsq_pkg::off_t'(4), 32'h2222_2222, 4'd7);
		push_instr(lsq_pkg::LS_STORE, 32'h24, lsq_pkg::off_t'(-8), 32'h3333_3333, 4'd9);
		drain_requests();
		bcast_mode = 1;

		// memory withholds credits, the buffer fills and dispatch stalls
		mem_hold = 1'b1;
		base_cnt = n_pushed;
		for (int i = 0; i < 10; i++)
			push_instr(lsq_pkg::LS_LOAD, lsq_pkg::data_t'(32'h100 + 4 * i), '0, '0, '0);
		repeat (20) @(posedge clk);
		if (n_req - base_cnt > MEM_CREDITS)
			abort_run("more requests than memory credits while credits were withheld");
		@(negedge clk);
		mem_hold = 1'b0;
		drain_requests();

		for (int i = 0; i < n_rand; i++)
			push_instr(rand_prog[i].op, rand_prog[i].base, rand_prog[i].off,
				rand_prog[i].val, rand_prog[i].tag);
		drain_requests();

		// a few quiet cycles so a stray pulse after the last request is still seen
		repeat (4) @(posedge clk);
		$display("Everything OK");
		$finish;
	end

endmodule
